/* design/burst_engine.sv */
`default_nettype none

`include "mem_defs.svh"

module burst_engine (
	input wire logic clk,
	input wire logic reset_n,
	input wire logic i_pending_i,
	input wire mem_pkg::addr_t i_addr_i,
	input wire logic d_pending_i,
	input wire mem_pkg::d_req_t d_payload_i,
	input wire logic pf_hit_i,
	input wire mem_pkg::line_t pf_line_i,
	output logic i_done_o,
	output logic d_done_o,
	output logic i_resp_o,
	output logic d_resp_o,
	output mem_pkg::line_t line_o,
	output logic fill_o,
	output mem_pkg::addr_t fill_addr_o,
	output mem_pkg::line_t fill_line_o,
	output logic read_o,
	output logic write_o,
	output mem_pkg::addr_t address_o,
	output mem_pkg::beat_t mem_wdata_o,
	input wire logic mem_resp_i,
	input wire mem_pkg::beat_t mem_rdata_i,
	output logic busy_o
);

	localparam logic [1:0] LAST_BEAT = 2'(`MEM_BEATS - 1);

	mem_pkg::eng_state_t state;
	logic [1:0] beat_cnt;
	logic src_d_q;
	logic rd_miss_q;
	logic pf_q;
	logic pf_valid_q;
	mem_pkg::addr_t pf_tag_q;
	mem_pkg::addr_t addr_q;
	mem_pkg::line_t line_q;

	logic d_write;
	mem_pkg::addr_t d_addr;
	mem_pkg::line_t d_line;
	mem_pkg::addr_t next_addr;
	logic go_pf;
	logic in_burst;

	assign d_write = d_payload_i[`MEM_LINE_W + `MEM_ADDR_W];
	assign d_addr = d_payload_i[`MEM_LINE_W +: `MEM_ADDR_W];
	assign d_line = d_payload_i[`MEM_LINE_W-1:0];

	assign next_addr = addr_q + `MEM_LINE_BYTES;
	assign in_burst = (state == mem_pkg::READ) || (state == mem_pkg::WRITE) ||
		(state == mem_pkg::PREFETCH);

	// Skip the prefetch when the next line is already buffered
	assign go_pf = (state == mem_pkg::RESP) && rd_miss_q &&
		!(pf_valid_q && (pf_tag_q == next_addr));

	always_ff @(posedge clk, posedge reset_n) begin
		if (reset_n) begin
			state <= mem_pkg::IDLE;
			beat_cnt <= 2'd0;
			src_d_q <= 1'b0;
			rd_miss_q <= 1'b0;
			pf_q <= 1'b0;
			pf_valid_q <= 1'b0;
		end else begin
			case (state)
				mem_pkg::IDLE: begin
					pf_q <= 1'b0;
					if (d_pending_i) begin
						src_d_q <= 1'b1;
						if (d_write) begin
							state <= mem_pkg::WRITE;
							if (pf_tag_q == d_addr) begin
								pf_valid_q <= 1'b0;
							end
						end else if (pf_hit_i) begin
							state <= mem_pkg::RESP;
						end else begin
							state <= mem_pkg::READ;
							rd_miss_q <= 1'b1;
						end
					end else if (i_pending_i) begin
						src_d_q <= 1'b0;
						state <= mem_pkg::READ;
					end
				end
				mem_pkg::READ, mem_pkg::WRITE, mem_pkg::PREFETCH: begin
					if (mem_resp_i) begin
						// Counter wraps back to zero after the last beat
						beat_cnt <= beat_cnt + 2'd1;
						if (beat_cnt == LAST_BEAT) begin
							state <= mem_pkg::RESP;
						end
					end
				end
				mem_pkg::RESP: begin
					rd_miss_q <= 1'b0;
					pf_q <= go_pf;
					if (pf_q) begin
						pf_valid_q <= 1'b1;
					end
					state <= go_pf ? mem_pkg::PREFETCH : mem_pkg::IDLE;
				end
				default: begin
					state <= mem_pkg::IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == mem_pkg::IDLE) begin
			if (d_pending_i) begin
				addr_q <= d_addr;
				line_q <= d_write ? d_line : pf_line_i;
			end else if (i_pending_i) begin
				addr_q <= i_addr_i;
			end
		end else if (in_burst && state != mem_pkg::WRITE && mem_resp_i) begin
			// Beats arrive lowest first and shift down into place
			line_q <= {mem_rdata_i, line_q[`MEM_LINE_W-1:`MEM_BEAT_W]};
		end else if (go_pf) begin
			addr_q <= next_addr;
		end
		if (state == mem_pkg::RESP && pf_q) begin
			pf_tag_q <= addr_q;
		end
	end

	assign read_o = (state == mem_pkg::READ) || (state == mem_pkg::PREFETCH);
	assign write_o = (state == mem_pkg::WRITE);
	assign address_o = addr_q;
	assign mem_wdata_o = line_q[beat_cnt * `MEM_BEAT_W +: `MEM_BEAT_W];

	assign i_resp_o = (state == mem_pkg::RESP) && !pf_q && !src_d_q;
	assign d_resp_o = (state == mem_pkg::RESP) && !pf_q && src_d_q;
	assign i_done_o = i_resp_o;
	assign d_done_o = d_resp_o;
	assign line_o = line_q;

	assign fill_o = (state == mem_pkg::RESP) && pf_q;
	assign fill_addr_o = addr_q;
	assign fill_line_o = line_q;

	assign busy_o = (state != mem_pkg::IDLE);

endmodule

`default_nettype wire

/* design/mem_pkg.sv */
`default_nettype none

`include "mem_defs.svh"

package mem_pkg;

	typedef logic [`MEM_ADDR_W-1:0] addr_t;
	typedef logic [`MEM_LINE_W-1:0] line_t;
	typedef logic [`MEM_BEAT_W-1:0] beat_t;

	// Write flag on top, then address, line in the low bits
	typedef logic [`MEM_LINE_W+`MEM_ADDR_W:0] d_req_t;

	typedef enum logic [2:0] {
		IDLE,
		READ,
		WRITE,
		PREFETCH,
		RESP
	} eng_state_t;

endpackage

`default_nettype wire

/* design/mem_subsys_top.sv */
`default_nettype none

`include "mem_defs.svh"

module mem_subsys_top (
	input wire logic clk,
	input wire logic reset_n,
	input wire logic i_read_i,
	input wire mem_pkg::addr_t i_addr_i,
	output logic i_resp_o,
	output mem_pkg::line_t i_line_o,
	input wire logic d_read_i,
	input wire logic d_write_i,
	input wire mem_pkg::addr_t d_addr_i,
	input wire mem_pkg::line_t d_line_i,
	output logic d_resp_o,
	output mem_pkg::line_t d_line_o,
	output logic read_o,
	output logic write_o,
	output mem_pkg::addr_t address_o,
	output mem_pkg::beat_t mem_wdata_o,
	input wire logic mem_resp_i,
	input wire mem_pkg::beat_t mem_rdata_i,
	output logic stall_o
);

	logic i_pending;
	logic i_done;
	mem_pkg::addr_t i_addr;
	logic d_pending;
	logic d_done;
	mem_pkg::d_req_t d_payload;
	logic pf_hit;
	mem_pkg::line_t pf_line;
	logic fill;
	mem_pkg::addr_t fill_addr;
	mem_pkg::line_t fill_line;
	mem_pkg::line_t line;
	logic busy;

	req_slot #(.payload_t(mem_pkg::addr_t)) i_slot (
		.clk(clk),
		.reset_n(reset_n),
		.strobe_i(i_read_i),
		.payload_i(i_addr_i),
		.done_i(i_done),
		.pending_o(i_pending),
		.payload_o(i_addr)
	);

	req_slot #(.payload_t(mem_pkg::d_req_t)) d_slot (
		.clk(clk),
		.reset_n(reset_n),
		.strobe_i(d_read_i | d_write_i),
		.payload_i({d_write_i, d_addr_i, d_line_i}),
		.done_i(d_done),
		.pending_o(d_pending),
		.payload_o(d_payload)
	);

	prefetch_buf pf_buf (
		.clk(clk),
		.reset_n(reset_n),
		.lookup_addr_i(d_payload[`MEM_LINE_W +: `MEM_ADDR_W]),
		.lookup_valid_i(d_pending),
		.lookup_write_i(d_payload[`MEM_LINE_W + `MEM_ADDR_W]),
		.fill_i(fill),
		.fill_addr_i(fill_addr),
		.fill_line_i(fill_line),
		.hit_o(pf_hit),
		.hit_line_o(pf_line)
	);

	burst_engine engine (
		.clk(clk),
		.reset_n(reset_n),
		.i_pending_i(i_pending),
		.i_addr_i(i_addr),
		.d_pending_i(d_pending),
		.d_payload_i(d_payload),
		.pf_hit_i(pf_hit),
		.pf_line_i(pf_line),
		.i_done_o(i_done),
		.d_done_o(d_done),
		.i_resp_o(i_resp_o),
		.d_resp_o(d_resp_o),
		.line_o(line),
		.fill_o(fill),
		.fill_addr_o(fill_addr),
		.fill_line_o(fill_line),
		.read_o(read_o),
		.write_o(write_o),
		.address_o(address_o),
		.mem_wdata_o(mem_wdata_o),
		.mem_resp_i(mem_resp_i),
		.mem_rdata_i(mem_rdata_i),
		.busy_o(busy)
	);

	// One line register serves both caches
	assign i_line_o = line;
	assign d_line_o = line;

	assign stall_o = i_pending | d_pending | busy;

endmodule

`default_nettype wire

/* design/prefetch_buf.sv */
`default_nettype none

module prefetch_buf (
	input wire logic clk,
	input wire logic reset_n,
	input wire mem_pkg::addr_t lookup_addr_i,
	input wire logic lookup_valid_i,
	input wire logic lookup_write_i,
	input wire logic fill_i,
	input wire mem_pkg::addr_t fill_addr_i,
	input wire mem_pkg::line_t fill_line_i,
	output logic hit_o,
	output mem_pkg::line_t hit_line_o
);

	logic valid_q;
	mem_pkg::addr_t tag_q;
	mem_pkg::line_t line_q;
	logic tag_match;

	assign tag_match = valid_q && (lookup_addr_i == tag_q);

	always_ff @(posedge clk, posedge reset_n) begin
		if (reset_n) begin
			valid_q <= 1'b0;
		end else if (lookup_valid_i && lookup_write_i && tag_match) begin
			// Pending write makes the buffered copy stale
			valid_q <= 1'b0;
		end else if (fill_i) begin
			valid_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_i) begin
			tag_q <= fill_addr_i;
			line_q <= fill_line_i;
		end
	end

	assign hit_o = lookup_valid_i && !lookup_write_i && tag_match;
	assign hit_line_o = line_q;

endmodule

`default_nettype wire

/* design/req_slot.sv */
`default_nettype none

module req_slot #(
	parameter type payload_t = logic
) (
	input wire logic clk,
	input wire logic reset_n,
	input wire logic strobe_i,
	input wire payload_t payload_i,
	input wire logic done_i,
	output logic pending_o,
	output payload_t payload_o
);

	logic pending_q;
	payload_t payload_q;

	always_ff @(posedge clk, posedge reset_n) begin
		if (reset_n) begin
			pending_q <= 1'b0;
		end else if (strobe_i) begin
			pending_q <= 1'b1;
		end else if (done_i) begin
			pending_q <= 1'b0;
		end
	end

	// Held until the engine reports done
	always_ff @(posedge clk) begin
		if (strobe_i) begin
			payload_q <= payload_i;
		end
	end

	assign pending_o = pending_q;
	assign payload_o = payload_q;

endmodule

`default_nettype wire

/* include/mem_defs.svh */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Cache line and memory beat sizes
`define MEM_LINE_W 256
`define MEM_BEAT_W 64
`define MEM_ADDR_W 32

// Beats per line transfer
`define MEM_BEATS 4

// Address step between consecutive lines
`define MEM_LINE_BYTES 32

`endif

/* run.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --assert --timing --timescale 1ns/1ps \
	-f sim.f --top-module tb_mem_subsys -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_mem_subsys +verilator+error+limit+1000 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx 'ALL TESTS PASSED'; then
	exit 0
fi
exit 1

/* sim.f */
+incdir+include
design/mem_pkg.sv
design/req_slot.sv
design/prefetch_buf.sv
design/burst_engine.sv
design/mem_subsys_top.sv
tb/mem_model.sv
tb/mem_subsys_props.sv
tb/tb_mem_subsys.sv

/* tb/mem_model.sv */
`default_nettype none

`include "mem_defs.svh"

module mem_model (
	input wire logic clk,
	input wire logic reset_n,
	input wire logic read_i,
	input wire logic write_i,
	input wire mem_pkg::addr_t address_i,
	input wire mem_pkg::beat_t wdata_i,
	output logic resp_o,
	output mem_pkg::beat_t rdata_o
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [31:0] rng_state = 32'd85;
	logic [31:0] rng_next;
	logic resp_q = 1'b0;
	mem_pkg::beat_t rdata_q = '0;
	logic [1:0] beat;
	logic [1:0] delay;

	// Beats written so far, keyed by line address and beat index
	mem_pkg::beat_t store [logic [`MEM_ADDR_W+1:0]];

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Unwritten beats hold the line address above the beat index
	function automatic mem_pkg::beat_t beat_at(input mem_pkg::addr_t a, input logic [1:0] k);
		if (store.exists({a, k})) begin
			return store[{a, k}];
		end
		return {a, 30'd0, k};
	endfunction

	assign rng_next = xorshift32(rng_state);

	always @(negedge clk) begin
		if (reset_n || !(read_i || write_i)) begin
			resp_q <= 1'b0;
			beat <= 2'd0;
			delay <= rng_state[1:0];
		end else if (delay != 2'd0) begin
			resp_q <= 1'b0;
			delay <= delay - 2'd1;
		end else begin
			// Beat completes at the next rising edge
			resp_q <= 1'b1;
			if (write_i) begin
				store[{address_i, beat}] = wdata_i;
			end
			rdata_q <= beat_at(address_i, beat);
			beat <= beat + 2'd1;
			rng_state <= rng_next;
			delay <= rng_next[1:0];
		end
	end

	assign resp_o = resp_q;
	assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* tb/mem_subsys_props.sv */
`default_nettype none

module mem_subsys_props (
	input wire logic clk,
	input wire logic reset_n,
	input wire logic i_read_i,
	input wire logic d_read_i,
	input wire logic d_write_i,
	input wire logic i_resp_i,
	input wire logic d_resp_i,
	input wire logic read_i,
	input wire logic write_i,
	input wire mem_pkg::addr_t address_i,
	input wire logic stall_i,
	input wire logic d_pending_i,
	input wire logic pf_hit_i,
	input wire logic busy_i
);

	timeunit 1ns;
	timeprecision 100ps;

	int n_quiet = 0;
	int n_excl = 0;
	int n_addr = 0;
	int n_ipulse = 0;
	int n_dpulse = 0;
	int n_stall = 0;
	int n_hit = 0;
	int fail_cnt;

	logic strobe_seen;
	logic i_open;
	logic d_open;

	assign fail_cnt = n_quiet + n_excl + n_addr + n_ipulse + n_dpulse + n_stall + n_hit;

	// Requests between strobe and response
	always_ff @(posedge clk, posedge reset_n) begin
		if (reset_n) begin
			strobe_seen <= 1'b0;
			i_open <= 1'b0;
			d_open <= 1'b0;
		end else begin
			if (i_read_i || d_read_i || d_write_i) begin
				strobe_seen <= 1'b1;
			end
			if (i_read_i) begin
				i_open <= 1'b1;
			end else if (i_resp_i) begin
				i_open <= 1'b0;
			end
			if (d_read_i || d_write_i) begin
				d_open <= 1'b1;
			end else if (d_resp_i) begin
				d_open <= 1'b0;
			end
		end
	end

	quiet_after_reset: assert property (@(posedge clk) disable iff (reset_n)
		!strobe_seen |-> !(stall_i || read_i || write_i || i_resp_i || d_resp_i))
		else begin
			n_quiet = n_quiet + 1;
			$error("control output active before any strobe");
		end

	read_write_excl: assert property (@(posedge clk) disable iff (reset_n)
		!(read_i && write_i))
		else begin
			n_excl = n_excl + 1;
			$error("read and write requested together");
		end

	addr_stable: assert property (@(posedge clk) disable iff (reset_n)
		((read_i && $past(read_i)) || (write_i && $past(write_i))) |-> $stable(address_i))
		else begin
			n_addr = n_addr + 1;
			$error("address changed during a burst");
		end

	i_resp_pulse: assert property (@(posedge clk) disable iff (reset_n) i_resp_i |=> !i_resp_i)
		else begin
			n_ipulse = n_ipulse + 1;
			$error("instruction response longer than one cycle");
		end

	d_resp_pulse: assert property (@(posedge clk) disable iff (reset_n) d_resp_i |=> !d_resp_i)
		else begin
			n_dpulse = n_dpulse + 1;
			$error("data response longer than one cycle");
		end

	stall_while_open: assert property (@(posedge clk) disable iff (reset_n)
		(i_open || d_open) |-> stall_i)
		else begin
			n_stall = n_stall + 1;
			$error("stall low while a request is outstanding");
		end

	// Prefetch hit answers straight from the buffer
	hit_no_mem: assert property (@(posedge clk) disable iff (reset_n)
		(d_pending_i && pf_hit_i && !busy_i) |=> (d_resp_i && !read_i && !write_i))
		else begin
			n_hit = n_hit + 1;
			$error("prefetch hit did not respond without memory access");
		end

endmodule

`default_nettype wire

/* tb/tb_mem_subsys.sv */
`default_nettype none

`include "mem_defs.svh"

module tb_mem_subsys;

	timeunit 1ns;
	timeprecision 100ps;

	// About 12 bursts of up to 20 cycles each, plus gaps, with a wide margin
	localparam int MAX_CYCLES = 2000;

	logic clk = 1'b0;
	logic reset_n = 1'b1;
	logic i_read = 1'b0;
	mem_pkg::addr_t i_addr = '0;
	logic d_read = 1'b0;
	logic d_write = 1'b0;
	mem_pkg::addr_t d_addr = '0;
	mem_pkg::line_t d_wr_line = '0;

	logic i_resp;
	logic d_resp;
	mem_pkg::line_t i_line;
	mem_pkg::line_t d_rd_line;
	logic read;
	logic write;
	mem_pkg::addr_t address;
	mem_pkg::beat_t wdata;
	logic mem_resp;
	mem_pkg::beat_t rdata;
	logic stall;

	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycles = 0;
	mem_pkg::line_t i_got;
	mem_pkg::line_t d_got;
	int i_at;
	int d_at;
	bit mem_seen;
	mem_pkg::line_t written [mem_pkg::addr_t];

	mem_subsys_top dut0 (
		.clk(clk),
		.reset_n(reset_n),
		.i_read_i(i_read),
		.i_addr_i(i_addr),
		.i_resp_o(i_resp),
		.i_line_o(i_line),
		.d_read_i(d_read),
		.d_write_i(d_write),
		.d_addr_i(d_addr),
		.d_line_i(d_wr_line),
		.d_resp_o(d_resp),
		.d_line_o(d_rd_line),
		.read_o(read),
		.write_o(write),
		.address_o(address),
		.mem_wdata_o(wdata),
		.mem_resp_i(mem_resp),
		.mem_rdata_i(rdata),
		.stall_o(stall)
	);

	mem_model mem0 (
		.clk(clk),
		.reset_n(reset_n),
		.read_i(read),
		.write_i(write),
		.address_i(address),
		.wdata_i(wdata),
		.resp_o(mem_resp),
		.rdata_o(rdata)
	);

	bind mem_subsys_top mem_subsys_props props0 (
		.clk(clk),
		.reset_n(reset_n),
		.i_read_i(i_read_i),
		.d_read_i(d_read_i),
		.d_write_i(d_write_i),
		.i_resp_i(i_resp_o),
		.d_resp_i(d_resp_o),
		.read_i(read_o),
		.write_i(write_o),
		.address_i(address_o),
		.stall_i(stall_o),
		.d_pending_i(d_pending),
		.pf_hit_i(pf_hit),
		.busy_i(busy)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			$display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// Initial memory content
	function automatic mem_pkg::line_t rule_line(input mem_pkg::addr_t a);
		mem_pkg::line_t l;
		int k;
		for (k = 0; k < `MEM_BEATS; k++) begin
			l[k*`MEM_BEAT_W +: `MEM_BEAT_W] = {a, 32'(k)};
		end
		return l;
	endfunction

	function automatic mem_pkg::line_t expected_line(input mem_pkg::addr_t a);
		if (written.exists(a)) begin
			return written[a];
		end
		return rule_line(a);
	endfunction

	function automatic mem_pkg::line_t make_line(input mem_pkg::addr_t tag);
		mem_pkg::line_t l;
		int k;
		for (k = 0; k < `MEM_BEATS; k++) begin
			l[k*`MEM_BEAT_W +: `MEM_BEAT_W] = {~tag, 16'hbeef, 16'(k)};
		end
		return l;
	endfunction

	task automatic strobe_data(input logic wr, input mem_pkg::addr_t a, input mem_pkg::line_t l);
		@(negedge clk);
		d_read = !wr;
		d_write = wr;
		d_addr = a;
		d_wr_line = l;
		if (wr) begin
			written[a] = l;
		end
	endtask

	// Counts falling edges from the strobe until the wanted responses arrive
	task automatic await_resp(input bit want_i, input bit want_d);
		bit got_i;
		bit got_d;
		int n;
		got_i = !want_i;
		got_d = !want_d;
		n = 0;
		mem_seen = 1'b0;
		while (!(got_i && got_d)) begin
			@(negedge clk);
			i_read = 1'b0;
			d_read = 1'b0;
			d_write = 1'b0;
			n++;
			mem_seen = mem_seen | read | write;
			if (i_resp) begin
				got_i = 1'b1;
				i_got = i_line;
				i_at = n;
			end
			if (d_resp) begin
				got_d = 1'b1;
				d_got = d_rd_line;
				d_at = n;
			end
		end
	endtask

	task automatic wait_idle();
		@(negedge clk);
		while (stall) begin
			@(negedge clk);
		end
	endtask

	task automatic expect_true(input bit ok, input string msg);
		assert (ok) else begin
			errors++;
			$display("ERROR at %0d ns: %s", $time, msg);
		end
	endtask

	task automatic check_line(input string what, input mem_pkg::line_t got,
		input mem_pkg::line_t exp);
		assert (got === exp) else begin
			errors++;
			$display("ERROR at %0d ns: %s returned %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("test %0d, %s: passed", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d, %s: failed", tests_run, name);
		end
	endtask

	initial begin
		int e;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b0;

		e = errors;
		repeat (3) begin
			@(negedge clk);
			expect_true(!(stall || read || write || i_resp || d_resp), "control output after reset");
		end
		@(negedge clk);
		i_read = 1'b1;
		i_addr = 32'h0000_1000;
		await_resp(1'b1, 1'b0);
		check_line("instruction read", i_got, expected_line(32'h0000_1000));
		wait_idle();
		end_test("reset and instruction read", e);

		e = errors;
		strobe_data(1'b1, 32'h0000_2000, make_line(32'h0000_2000));
		await_resp(1'b0, 1'b1);
		strobe_data(1'b0, 32'h0000_2000, '0);
		await_resp(1'b0, 1'b1);
		check_line("read after write", d_got, expected_line(32'h0000_2000));
		wait_idle();
		end_test("data write then read", e);

		e = errors;
		strobe_data(1'b0, 32'h0000_3000, '0);
		await_resp(1'b0, 1'b1);
		check_line("read miss", d_got, expected_line(32'h0000_3000));
		wait_idle();
		strobe_data(1'b0, 32'h0000_3020, '0);
		await_resp(1'b0, 1'b1);
		check_line("prefetch hit", d_got, expected_line(32'h0000_3020));
		expect_true(!mem_seen, "prefetch hit reached memory");
		expect_true(d_at == 2, "prefetch hit response not two cycles after strobe");
		wait_idle();
		end_test("prefetch hit", e);

		e = errors;
		strobe_data(1'b1, 32'h0000_3020, make_line(32'h0000_3020));
		await_resp(1'b0, 1'b1);
		strobe_data(1'b0, 32'h0000_3020, '0);
		await_resp(1'b0, 1'b1);
		expect_true(mem_seen, "read after invalidating write did not reach memory");
		check_line("read after invalidation", d_got, expected_line(32'h0000_3020));
		wait_idle();
		end_test("write invalidates prefetch", e);

		e = errors;
		strobe_data(1'b0, 32'h0000_6000, '0);
		i_read = 1'b1;
		i_addr = 32'h0000_5000;
		await_resp(1'b1, 1'b1);
		expect_true(d_at < i_at, "data request not served before instruction request");
		check_line("simultaneous data read", d_got, expected_line(32'h0000_6000));
		check_line("simultaneous instruction read", i_got, expected_line(32'h0000_5000));
		wait_idle();
		end_test("simultaneous requests", e);

		$display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
			tests_run, tests_failed, errors, dut0.props0.fail_cnt);
		if (tests_failed == 0 && dut0.props0.fail_cnt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
